//--- common/dh_fixed_pkg.sv
// DH fixed-point types
// Entry and product types plus the Taylor coefficients for sincos

`include "dh_params.svh"

package dh_fixed_pkg;

	// One matrix entry or angle
	typedef logic signed [`DH_FIX_W-1:0] fix_t;

	// Full-width product before rounding
	typedef logic signed [`DH_PROD_W-1:0] prod_t;

	localparam fix_t FIX_ONE = fix_t'(1 << `DH_FRAC_W);

	// Horner coefficients, each rounded to Q.8
	// sin = x(1 - x^2/6 (1 - x^2/20))
	// cos = 1 - x^2/2 (1 - x^2/12)
	localparam fix_t K_INV20 = fix_t'(13);
	localparam fix_t K_INV12 = fix_t'(21);
	localparam fix_t K_INV6  = fix_t'(43);
	localparam fix_t K_INV2  = fix_t'(128);

endpackage

//--- common/dh_params.svh
// DH link transform parameters
// Fixed-point widths, pipeline latencies and APB bus widths

`ifndef DH_PARAMS_SVH
`define DH_PARAMS_SVH

// Matrix entries are Q18.8, 256 is 1.0
`define DH_FIX_W      27
`define DH_FRAC_W     8
`define DH_PROD_W     54

// Pipeline latencies in enabled cycles
`define DH_MULT_LAT   2
`define DH_SINCOS_LAT 10
`define DH_LAT        12

// APB3 slave
`define DH_APB_AW     8
`define DH_APB_DW     32

// pi/2 in Q.8, largest legal angle magnitude
`define DH_ANGLE_MAX  402

`endif

//--- common/dh_regs_pkg.sv
// DH register map
// APB byte offsets of the parameter, control, status and matrix registers

`include "dh_params.svh"

package dh_regs_pkg;

	typedef logic [`DH_APB_AW-1:0] apb_addr_t;

	// Link parameters, read/write
	localparam apb_addr_t REG_THETA  = 8'h00;
	localparam apb_addr_t REG_ALPHA  = 8'h04;
	localparam apb_addr_t REG_LINK_A = 8'h08;
	localparam apb_addr_t REG_LINK_D = 8'h0C;

	// Command and state
	localparam apb_addr_t REG_CTRL   = 8'h10;
	localparam apb_addr_t REG_STATUS = 8'h14;

	// Entry r,c at MATRIX_BASE + 4*(4r+c), read only
	localparam apb_addr_t MATRIX_BASE = 8'h40;

	// Bit positions
	localparam int CTRL_START  = 0;
	localparam int STATUS_BUSY = 0;
	localparam int STATUS_DONE = 1;

endpackage

//--- dv/dh_ref.svh
// DH reference model
// Rounded multiply, Horner sine/cosine and the link matrix, bit for bit

`ifndef DH_REF_SVH
`define DH_REF_SVH

// Keep product bits 34:8, round up on bit 7
function automatic fix_t ref_mult(input fix_t a, input fix_t b);
	longint p;
	longint q;
	p = longint'(a) * longint'(b);
	q = (p >>> `DH_FRAC_W) + ((p >>> (`DH_FRAC_W - 1)) & 64'sd1);
	return fix_t'(q);
endfunction

// sin = x(1 - x^2/6 (1 - x^2/20)), cos = 1 - x^2/2 (1 - x^2/12)
function automatic void ref_sincos(input fix_t x, output fix_t s, output fix_t c);
	fix_t x2;
	fix_t ts;
	fix_t tc;
	x2 = ref_mult(x, x);
	ts = ref_mult(x2, FIX_ONE - ref_mult(x2, K_INV20));
	ts = ref_mult(ts, K_INV6);
	s = ref_mult(x, FIX_ONE - ts);
	tc = ref_mult(x2, FIX_ONE - ref_mult(x2, K_INV12));
	tc = ref_mult(tc, K_INV2);
	c = FIX_ONE - tc;
endfunction

// Entry r,c lands in m[4r+c]
function automatic void ref_matrix(input fix_t theta, input fix_t alpha,
	input fix_t link_a, input fix_t link_d, output fix_t m [16]);
	fix_t st;
	fix_t ct;
	fix_t sa;
	fix_t ca;
	ref_sincos(theta, st, ct);
	ref_sincos(alpha, sa, ca);
	m[0] = ct;
	m[1] = ref_mult(-st, ca);
	m[2] = ref_mult(st, sa);
	m[3] = ref_mult(link_a, ct);
	m[4] = st;
	m[5] = ref_mult(ct, ca);
	m[6] = ref_mult(ct, -sa);
	m[7] = ref_mult(link_a, st);
	m[8] = '0;
	m[9] = sa;
	m[10] = ca;
	m[11] = link_d;
	m[12] = '0;
	m[13] = '0;
	m[14] = '0;
	m[15] = FIX_ONE;
endfunction

`endif

//--- dv/dh_tb.sv
// DH link transform testbench
// Drives dh_top over APB and checks every read against the reference model

`timescale 1ns/1ps
`include "dh_params.svh"

module dh_tb;
	import dh_fixed_pkg::*;
	import dh_regs_pkg::*;

	`include "dh_ref.svh"

	localparam int NUM_JOBS = 24;
	localparam int WATCHDOG_CYCLES = NUM_JOBS * (`DH_LAT + 60) + 200;
	localparam int POLL_LIMIT = 50;

	logic                  i_clk;
	logic                  i_rst_n;
	logic                  i_psel;
	logic                  i_penable;
	logic                  i_pwrite;
	logic [`DH_APB_AW-1:0] i_paddr;
	logic [`DH_APB_DW-1:0] i_pwdata;
	logic                  o_pready;
	logic [`DH_APB_DW-1:0] o_prdata;
	logic                  o_pslverr;

	integer    seed;
	int        errors;
	int        test_errors;
	int        tests_run;
	int        tests_failed;
	fix_t      exp_mat [16];
	fix_t      prev_mat [16];
	apb_addr_t par_addr [4] = '{REG_THETA, REG_ALPHA, REG_LINK_A, REG_LINK_D};
	string     par_name [4] = '{"theta", "alpha", "link_a", "link_d"};

	dh_top i_dut (.*);

	always #2 i_clk = ~i_clk;

	function automatic logic [`DH_APB_DW-1:0] sext(input fix_t v);
		return {{(`DH_APB_DW - `DH_FIX_W){v[`DH_FIX_W-1]}}, v};
	endfunction

	// Called at a falling edge, returns at one, two clocks per transfer
	task automatic apb_transfer(input logic wr, input apb_addr_t addr,
		input logic [`DH_APB_DW-1:0] wdata, output logic [`DH_APB_DW-1:0] rdata,
		output logic err);
		i_psel = 1'b1;
		i_penable = 1'b0;
		i_pwrite = wr;
		i_paddr = addr;
		i_pwdata = wdata;
		@(negedge i_clk);
		i_penable = 1'b1;
		#1;
		rdata = o_prdata;
		err = o_pslverr;
		if (o_pready !== 1'b1) begin
			$display("pready was low in the access phase at address 0x%02h", addr);
			test_errors++;
		end
		@(negedge i_clk);
		i_psel = 1'b0;
		i_penable = 1'b0;
	endtask

	task automatic write_reg(input apb_addr_t addr, input logic [`DH_APB_DW-1:0] data,
		output logic err);
		logic [`DH_APB_DW-1:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic read_reg(input apb_addr_t addr, output logic [`DH_APB_DW-1:0] data,
		output logic err);
		apb_transfer(1'b0, addr, '0, data, err);
	endtask

	task automatic check_word(input string name, input logic [`DH_APB_DW-1:0] exp,
		input logic [`DH_APB_DW-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
			test_errors++;
		end
	endtask

	task automatic read_expect(input apb_addr_t addr, input string name,
		input logic [`DH_APB_DW-1:0] exp, input logic exp_err);
		logic [`DH_APB_DW-1:0] data;
		logic err;
		read_reg(addr, data, err);
		check_word({name, ".pslverr"}, 32'(exp_err), 32'(err));
		check_word(name, exp, data);
	endtask

	task automatic write_expect(input apb_addr_t addr, input logic [`DH_APB_DW-1:0] data,
		input logic exp_err);
		logic err;
		write_reg(addr, data, err);
		check_word($sformatf("pslverr of write to 0x%02h", addr), 32'(exp_err), 32'(err));
	endtask

	task automatic check_matrix(input fix_t m [16]);
		for (int i = 0; i < 16; i++) begin
			read_expect(MATRIX_BASE + apb_addr_t'(4 * i), $sformatf("m%0d%0d", i / 4, i % 4),
				sext(m[i]), 1'b0);
		end
	endtask

	task automatic load_params(input fix_t theta, input fix_t alpha, input fix_t link_a,
		input fix_t link_d);
		write_expect(REG_THETA, sext(theta), 1'b0);
		write_expect(REG_ALPHA, sext(alpha), 1'b0);
		write_expect(REG_LINK_A, sext(link_a), 1'b0);
		write_expect(REG_LINK_D, sext(link_d), 1'b0);
	endtask

	task automatic wait_done();
		logic [`DH_APB_DW-1:0] st;
		logic err;
		int polls;
		st = '0;
		polls = 0;
		while (!st[STATUS_DONE] && polls < POLL_LIMIT) begin
			read_reg(REG_STATUS, st, err);
			polls++;
		end
		if (!st[STATUS_DONE]) begin
			$display("job did not finish within %0d status polls", POLL_LIMIT);
			test_errors++;
		end
	endtask

	task automatic run_job(input fix_t theta, input fix_t alpha, input fix_t link_a,
		input fix_t link_d);
		load_params(theta, alpha, link_a, link_d);
		write_expect(REG_CTRL, 32'(1) << CTRL_START, 1'b0);
		wait_done();
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0d %s: pass", tests_run, name);
		end else begin
			$display("test %0d %s: fail with %0d errors", tests_run, name, test_errors);
			tests_failed++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clk);
		$display("watchdog expired after %0d cycles, the run was stopped", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		logic [`DH_APB_DW-1:0] wval;
		fix_t th;
		fix_t al;
		fix_t la;
		fix_t ld;
		seed = 32'h539d;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_rst_n = 1'b1;

		// Reset values, then write and read back with junk in the top bits
		for (int i = 0; i < 4; i++) begin
			read_expect(par_addr[i], par_name[i], '0, 1'b0);
		end
		read_expect(REG_STATUS, "status", '0, 1'b0);
		for (int i = 0; i < 4; i++) begin
			wval = $random(seed);
			write_expect(par_addr[i], wval, 1'b0);
			read_expect(par_addr[i], par_name[i], sext(wval[`DH_FIX_W-1:0]), 1'b0);
		end
		end_test("register readback");

		// Zero angles give the identity rotation
		run_job('0, '0, 27'sd512, 27'sd300);
		for (int i = 0; i < 16; i++) begin
			exp_mat[i] = '0;
		end
		exp_mat[0] = FIX_ONE;
		exp_mat[3] = 27'sd512;
		exp_mat[5] = FIX_ONE;
		exp_mat[10] = FIX_ONE;
		exp_mat[11] = 27'sd300;
		exp_mat[15] = FIX_ONE;
		check_matrix(exp_mat);
		end_test("zero angles");

		repeat (20) begin
			th = fix_t'($random(seed) % (`DH_ANGLE_MAX + 1));
			al = fix_t'($random(seed) % (`DH_ANGLE_MAX + 1));
			la = fix_t'($random(seed) % 65537);
			ld = fix_t'($random(seed) % 65537);
			ref_matrix(th, al, la, ld, exp_mat);
			run_job(th, al, la, ld);
			check_matrix(exp_mat);
		end
		end_test("random jobs");

		// Second start lands while the first job is still running
		load_params(27'sd300, -27'sd200, 27'sd1000, -27'sd500);
		ref_matrix(27'sd300, -27'sd200, 27'sd1000, -27'sd500, exp_mat);
		write_expect(REG_CTRL, 32'(1) << CTRL_START, 1'b0);
		read_expect(REG_STATUS, "status", 32'(1) << STATUS_BUSY, 1'b0);
		write_expect(REG_CTRL, 32'(1) << CTRL_START, 1'b1);
		wait_done();
		read_expect(REG_STATUS, "status", 32'(1) << STATUS_DONE, 1'b0);
		check_matrix(exp_mat);
		prev_mat = exp_mat;
		end_test("start while busy");

		read_expect(8'h18, "unmapped", '0, 1'b1);
		read_expect(8'h3C, "unmapped", '0, 1'b1);
		read_expect(8'h7E, "unmapped", '0, 1'b1);
		read_expect(8'h80, "unmapped", '0, 1'b1);
		read_expect(8'h41, "unmapped", '0, 1'b1);
		read_expect(8'hFC, "unmapped", '0, 1'b1);
		write_expect(8'h18, '1, 1'b1);
		write_expect(8'h80, '1, 1'b1);
		write_expect(8'h41, '1, 1'b1);
		write_expect(REG_STATUS, '1, 1'b1);
		write_expect(MATRIX_BASE, '1, 1'b1);
		write_expect(MATRIX_BASE + 8'd60, '1, 1'b1);
		// Refused writes leave everything as it was
		read_expect(REG_STATUS, "status", 32'(1) << STATUS_DONE, 1'b0);
		read_expect(REG_THETA, "theta", sext(27'sd300), 1'b0);
		check_matrix(prev_mat);
		end_test("address errors");

		run_job(27'sd100, 27'sd50, 27'sd2000, 27'sd700);
		ref_matrix(27'sd100, 27'sd50, 27'sd2000, 27'sd700, prev_mat);
		check_matrix(prev_mat);
		load_params(-27'sd250, 27'sd380, -27'sd3000, 27'sd1234);
		ref_matrix(-27'sd250, 27'sd380, -27'sd3000, 27'sd1234, exp_mat);
		write_expect(REG_CTRL, 32'(1) << CTRL_START, 1'b0);
		read_expect(REG_STATUS, "status", 32'(1) << STATUS_BUSY, 1'b0);
		// Old result still visible mid job
		read_expect(MATRIX_BASE + 8'd12, "m03", sext(prev_mat[3]), 1'b0);
		read_expect(MATRIX_BASE + 8'd28, "m13", sext(prev_mat[7]), 1'b0);
		read_expect(MATRIX_BASE, "m00", sext(prev_mat[0]), 1'b0);
		wait_done();
		check_matrix(exp_mat);
		end_test("back to back jobs");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- sincos/sincos.sv
// Polynomial sine and cosine
// Truncated Taylor series in Horner form, five multiply levels
// Angle must be within +-pi/2, result after ten enabled cycles

`timescale 1ns/1ps
`include "dh_params.svh"

module sincos (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_en,
	input  dh_fixed_pkg::fix_t i_angle,
	output dh_fixed_pkg::fix_t o_sin,
	output dh_fixed_pkg::fix_t o_cos
);
	import dh_fixed_pkg::*;

	localparam int X_DLY = `DH_SINCOS_LAT - `DH_MULT_LAT;
	localparam int M_DLY = `DH_MULT_LAT;

	fix_t x2;
	fix_t p20;
	fix_t p12;
	fix_t s3;
	fix_t c3;
	fix_t s4;
	fix_t c4;
	fix_t x_dly [X_DLY];
	fix_t x2_dly [M_DLY];
	fix_t cos_dly [M_DLY];

	// Level 1: x^2
	fix_mult u_mult_sq (
		.i_clk, .i_rst_n, .i_en,
		.i_a (i_angle),
		.i_b (i_angle),
		.o_p (x2)
	);

	// Level 2: innermost Horner terms
	fix_mult u_mult_k20 (
		.i_clk, .i_rst_n, .i_en,
		.i_a (x2),
		.i_b (K_INV20),
		.o_p (p20)
	);
	fix_mult u_mult_k12 (
		.i_clk, .i_rst_n, .i_en,
		.i_a (x2),
		.i_b (K_INV12),
		.o_p (p12)
	);

	// Level 3
	fix_mult u_mult_s3 (
		.i_clk, .i_rst_n, .i_en,
		.i_a (x2_dly[M_DLY-1]),
		.i_b (FIX_ONE - p20),
		.o_p (s3)
	);
	fix_mult u_mult_c3 (
		.i_clk, .i_rst_n, .i_en,
		.i_a (x2_dly[M_DLY-1]),
		.i_b (FIX_ONE - p12),
		.o_p (c3)
	);

	// Level 4: 1/6 for sine, 1/2 for cosine
	fix_mult u_mult_s4 (
		.i_clk, .i_rst_n, .i_en,
		.i_a (s3),
		.i_b (K_INV6),
		.o_p (s4)
	);
	fix_mult u_mult_c4 (
		.i_clk, .i_rst_n, .i_en,
		.i_a (c3),
		.i_b (K_INV2),
		.o_p (c4)
	);

	// Level 5: outer factor x for sine
	fix_mult u_mult_sin (
		.i_clk, .i_rst_n, .i_en,
		.i_a (x_dly[X_DLY-1]),
		.i_b (FIX_ONE - s4),
		.o_p (o_sin)
	);

	// Delay lines keep x, x^2 and cosine in step with the multipliers
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int k = 0; k < X_DLY; k++) begin
				x_dly[k] <= '0;
			end
			for (int k = 0; k < M_DLY; k++) begin
				x2_dly[k] <= '0;
				cos_dly[k] <= '0;
			end
		end else if (i_en) begin
			x_dly[0] <= i_angle;
			x2_dly[0] <= x2;
			cos_dly[0] <= FIX_ONE - c4;
			for (int k = 1; k < X_DLY; k++) begin
				x_dly[k] <= x_dly[k-1];
			end
			for (int k = 1; k < M_DLY; k++) begin
				x2_dly[k] <= x2_dly[k-1];
				cos_dly[k] <= cos_dly[k-1];
			end
		end
	end

	assign o_cos = cos_dly[M_DLY-1];

	// No range reduction here, the series is only good inside +-pi/2
	a_angle_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_en |-> (i_angle <= `DH_ANGLE_MAX) && (i_angle >= -`DH_ANGLE_MAX))
		else $error("sincos: angle %0d outside +-pi/2", i_angle);

endmodule

//--- t_block/t_block.sv
// DH link transform
// Builds the 4x4 homogeneous matrix from theta, alpha, a and d
// Twelve enabled cycles from parameters to matrix

`timescale 1ns/1ps
`include "dh_params.svh"

module t_block (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_en,
	input  dh_fixed_pkg::fix_t i_theta,
	input  dh_fixed_pkg::fix_t i_alpha,
	input  dh_fixed_pkg::fix_t i_link_a,
	input  dh_fixed_pkg::fix_t i_link_d,
	output dh_fixed_pkg::fix_t o_m00, o_m01, o_m02, o_m03,
	output dh_fixed_pkg::fix_t o_m10, o_m11, o_m12, o_m13,
	output dh_fixed_pkg::fix_t o_m20, o_m21, o_m22, o_m23,
	output dh_fixed_pkg::fix_t o_m30, o_m31, o_m32, o_m33
);
	import dh_fixed_pkg::*;

	localparam int DLY = `DH_MULT_LAT;

	fix_t sin_t;
	fix_t cos_t;
	fix_t sin_a;
	fix_t cos_a;
	fix_t sin_t_d [DLY];
	fix_t cos_t_d [DLY];
	fix_t sin_a_d [DLY];
	fix_t cos_a_d [DLY];
	fix_t link_d_d [DLY];

	sincos u_sincos_theta (
		.i_clk, .i_rst_n, .i_en,
		.i_angle (i_theta),
		.o_sin   (sin_t),
		.o_cos   (cos_t)
	);

	sincos u_sincos_alpha (
		.i_clk, .i_rst_n, .i_en,
		.i_angle (i_alpha),
		.o_sin   (sin_a),
		.o_cos   (cos_a)
	);

	// Row 0 products
	fix_mult u_mult_01 (.i_clk, .i_rst_n, .i_en, .i_a(-sin_t), .i_b(cos_a), .o_p(o_m01));
	fix_mult u_mult_02 (.i_clk, .i_rst_n, .i_en, .i_a(sin_t), .i_b(sin_a), .o_p(o_m02));
	fix_mult u_mult_03 (.i_clk, .i_rst_n, .i_en, .i_a(i_link_a), .i_b(cos_t), .o_p(o_m03));

	// Row 1 products
	fix_mult u_mult_11 (.i_clk, .i_rst_n, .i_en, .i_a(cos_t), .i_b(cos_a), .o_p(o_m11));
	fix_mult u_mult_12 (.i_clk, .i_rst_n, .i_en, .i_a(cos_t), .i_b(-sin_a), .o_p(o_m12));
	fix_mult u_mult_13 (.i_clk, .i_rst_n, .i_en, .i_a(i_link_a), .i_b(sin_t), .o_p(o_m13));

	// Plain entries wait out the multiplier latency
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int k = 0; k < DLY; k++) begin
				sin_t_d[k] <= '0;
				cos_t_d[k] <= '0;
				sin_a_d[k] <= '0;
				cos_a_d[k] <= '0;
				link_d_d[k] <= '0;
			end
		end else if (i_en) begin
			sin_t_d[0] <= sin_t;
			cos_t_d[0] <= cos_t;
			sin_a_d[0] <= sin_a;
			cos_a_d[0] <= cos_a;
			link_d_d[0] <= i_link_d;
			for (int k = 1; k < DLY; k++) begin
				sin_t_d[k] <= sin_t_d[k-1];
				cos_t_d[k] <= cos_t_d[k-1];
				sin_a_d[k] <= sin_a_d[k-1];
				cos_a_d[k] <= cos_a_d[k-1];
				link_d_d[k] <= link_d_d[k-1];
			end
		end
	end

	assign o_m00 = cos_t_d[DLY-1];
	assign o_m10 = sin_t_d[DLY-1];

	assign o_m20 = '0;
	assign o_m21 = sin_a_d[DLY-1];
	assign o_m22 = cos_a_d[DLY-1];
	assign o_m23 = link_d_d[DLY-1];

	// Homogeneous row
	assign o_m30 = '0;
	assign o_m31 = '0;
	assign o_m32 = '0;
	assign o_m33 = FIX_ONE;

endmodule

//--- verilog/dh_apb_regs.sv
// DH APB register file
// Link parameters, start/status sequencing and the captured result matrix

`timescale 1ns/1ps
`include "dh_params.svh"

module dh_apb_regs (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_psel,
	input  logic                   i_penable,
	input  logic                   i_pwrite,
	input  logic [`DH_APB_AW-1:0]  i_paddr,
	input  logic [`DH_APB_DW-1:0]  i_pwdata,
	output logic                   o_pready,
	output logic [`DH_APB_DW-1:0]  o_prdata,
	output logic                   o_pslverr,
	input  dh_fixed_pkg::fix_t     i_m00, i_m01, i_m02, i_m03,
	input  dh_fixed_pkg::fix_t     i_m10, i_m11, i_m12, i_m13,
	input  dh_fixed_pkg::fix_t     i_m20, i_m21, i_m22, i_m23,
	input  dh_fixed_pkg::fix_t     i_m30, i_m31, i_m32, i_m33,
	output dh_fixed_pkg::fix_t     o_theta,
	output dh_fixed_pkg::fix_t     o_alpha,
	output dh_fixed_pkg::fix_t     o_link_a,
	output dh_fixed_pkg::fix_t     o_link_d,
	output logic                   o_en
);
	import dh_fixed_pkg::*;
	import dh_regs_pkg::*;

	localparam int CNT_W = $clog2(`DH_LAT + 1);
	localparam int EXT_W = `DH_APB_DW - `DH_FIX_W;

	logic                  access;
	logic                  mapped;
	logic                  read_only;
	logic                  is_matrix;
	logic                  start_busy;
	logic                  err;
	logic                  wr_ok;
	logic [3:0]            mat_idx;
	logic [`DH_APB_DW-1:0] rd_word;
	logic                  busy;
	logic                  done;
	logic [CNT_W-1:0]      cnt;
	fix_t                  theta_q;
	fix_t                  alpha_q;
	fix_t                  link_a_q;
	fix_t                  link_d_q;
	fix_t                  mat_q [16];
	fix_t                  mat_in [16];

	assign mat_in = '{i_m00, i_m01, i_m02, i_m03,
		i_m10, i_m11, i_m12, i_m13,
		i_m20, i_m21, i_m22, i_m23,
		i_m30, i_m31, i_m32, i_m33};

	assign access = i_psel && i_penable;
	assign mat_idx = i_paddr[5:2];
	assign is_matrix = (i_paddr[7:6] == MATRIX_BASE[7:6]) && (i_paddr[1:0] == 2'b00);

	// Read mux and address classification
	always_comb begin
		mapped = 1'b1;
		read_only = 1'b0;
		rd_word = '0;
		case (i_paddr)
			REG_THETA:  rd_word = {{EXT_W{theta_q[`DH_FIX_W-1]}}, theta_q};
			REG_ALPHA:  rd_word = {{EXT_W{alpha_q[`DH_FIX_W-1]}}, alpha_q};
			REG_LINK_A: rd_word = {{EXT_W{link_a_q[`DH_FIX_W-1]}}, link_a_q};
			REG_LINK_D: rd_word = {{EXT_W{link_d_q[`DH_FIX_W-1]}}, link_d_q};
			REG_CTRL:   rd_word = '0;
			REG_STATUS: begin
				read_only = 1'b1;
				rd_word[STATUS_BUSY] = busy;
				rd_word[STATUS_DONE] = done;
			end
			default: begin
				read_only = 1'b1;
				mapped = is_matrix;
				rd_word = {{EXT_W{mat_q[mat_idx][`DH_FIX_W-1]}}, mat_q[mat_idx]};
			end
		endcase
	end

	assign start_busy = (i_paddr == REG_CTRL) && i_pwdata[CTRL_START] && busy;
	assign err = access && (!mapped || (i_pwrite && (read_only || start_busy)));
	assign wr_ok = access && i_pwrite && !err;

	assign o_pready = access;
	assign o_pslverr = err;
	assign o_prdata = (access && !i_pwrite && !err) ? rd_word : '0;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			theta_q <= '0;
			alpha_q <= '0;
			link_a_q <= '0;
			link_d_q <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
			for (int k = 0; k < 16; k++) begin
				mat_q[k] <= '0;
			end
		end else begin
			if (wr_ok) begin
				case (i_paddr)
					REG_THETA:  theta_q <= i_pwdata[`DH_FIX_W-1:0];
					REG_ALPHA:  alpha_q <= i_pwdata[`DH_FIX_W-1:0];
					REG_LINK_A: link_a_q <= i_pwdata[`DH_FIX_W-1:0];
					REG_LINK_D: link_d_q <= i_pwdata[`DH_FIX_W-1:0];
					REG_CTRL: begin
						if (i_pwdata[CTRL_START]) begin
							busy <= 1'b1;
							done <= 1'b0;
							cnt <= '0;
						end
					end
					default: ;
				endcase
			end
			// One extra enabled edge so the capture sees the settled matrix
			if (busy) begin
				if (cnt == CNT_W'(`DH_LAT)) begin
					busy <= 1'b0;
					done <= 1'b1;
					mat_q <= mat_in;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	assign o_theta = theta_q;
	assign o_alpha = alpha_q;
	assign o_link_a = link_a_q;
	assign o_link_d = link_d_q;
	assign o_en = busy;

	a_busy_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(busy && done))
		else $error("dh_apb_regs: busy and done both set");

endmodule

//--- verilog/dh_top.sv
// DH link transform subsystem
// APB register file driving the transform pipeline

`timescale 1ns/1ps
`include "dh_params.svh"

module dh_top (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_psel,
	input  logic                  i_penable,
	input  logic                  i_pwrite,
	input  logic [`DH_APB_AW-1:0] i_paddr,
	input  logic [`DH_APB_DW-1:0] i_pwdata,
	output logic                  o_pready,
	output logic [`DH_APB_DW-1:0] o_prdata,
	output logic                  o_pslverr
);
	import dh_fixed_pkg::*;

	fix_t theta;
	fix_t alpha;
	fix_t link_a;
	fix_t link_d;
	logic en;
	fix_t m00, m01, m02, m03;
	fix_t m10, m11, m12, m13;
	fix_t m20, m21, m22, m23;
	fix_t m30, m31, m32, m33;

	dh_apb_regs u_regs (
		.i_clk, .i_rst_n,
		.i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
		.o_pready, .o_prdata, .o_pslverr,
		.i_m00(m00), .i_m01(m01), .i_m02(m02), .i_m03(m03),
		.i_m10(m10), .i_m11(m11), .i_m12(m12), .i_m13(m13),
		.i_m20(m20), .i_m21(m21), .i_m22(m22), .i_m23(m23),
		.i_m30(m30), .i_m31(m31), .i_m32(m32), .i_m33(m33),
		.o_theta(theta), .o_alpha(alpha), .o_link_a(link_a), .o_link_d(link_d),
		.o_en(en)
	);

	t_block u_t_block (
		.i_clk, .i_rst_n,
		.i_en(en),
		.i_theta(theta), .i_alpha(alpha), .i_link_a(link_a), .i_link_d(link_d),
		.o_m00(m00), .o_m01(m01), .o_m02(m02), .o_m03(m03),
		.o_m10(m10), .o_m11(m11), .o_m12(m12), .o_m13(m13),
		.o_m20(m20), .o_m21(m21), .o_m22(m22), .o_m23(m23),
		.o_m30(m30), .o_m31(m31), .o_m32(m32), .o_m33(m33)
	);

endmodule

//--- verilog/fix_mult.sv
// Fixed-point multiplier
// Two-stage signed 27x27 multiply, rounded back to Q.8

`timescale 1ns/1ps
`include "dh_params.svh"

module fix_mult (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_en,
	input  dh_fixed_pkg::fix_t i_a,
	input  dh_fixed_pkg::fix_t i_b,
	output dh_fixed_pkg::fix_t o_p
);
	import dh_fixed_pkg::*;

	localparam int LSB = `DH_FRAC_W;
	localparam int MSB = `DH_FIX_W + `DH_FRAC_W - 1;
	localparam int TOP_W = `DH_PROD_W - MSB;

	prod_t prod_q;
	logic  fits;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			prod_q <= '0;
			o_p <= '0;
		end else if (i_en) begin
			prod_q <= i_a * i_b;
			// Round up when the first dropped bit is set
			o_p <= prod_q[MSB:LSB] + {{(`DH_FIX_W-1){1'b0}}, prod_q[LSB-1]};
		end
	end

	// Dropped top bits must all match the kept sign bit
	assign fits = (prod_q[`DH_PROD_W-1:MSB] == {TOP_W{prod_q[MSB]}});

	a_fits: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_en |-> fits)
		else $error("fix_mult: product %0d overflows the entry width", prod_q);

endmodule

//--- vlog.f
+incdir+common
+incdir+dv
common/dh_fixed_pkg.sv
common/dh_regs_pkg.sv
verilog/fix_mult.sv
sincos/sincos.sv
t_block/t_block.sv
verilog/dh_apb_regs.sv
verilog/dh_top.sv
dv/dh_tb.sv
